/* flist.f */
+incdir+tb
rtl/ppu_pkg.sv
rtl/tx_cfg_decode.sv
rtl/scanline_emu.sv
rtl/rgb_range_limiter.sv
rtl/ppu_tx_top.sv
tb/tb_ppu_tx.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns -Wno-fatal \
  --top-module tb_ppu_tx -f flist.f -o tb_ppu_tx

output=$(./obj_dir/tb_ppu_tx)
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx 'sim passed'; then
  exit 0
fi
exit 1

/* tb/ppu_tx_model.svh */
// reference model of the VCLK_Tx path, video mode choice, scanline darkening and range limit

`ifndef PPU_TX_MODEL_SVH
`define PPU_TX_MODEL_SVH

  // table first (forced or from the PAL flag), then the target resolution
  function automatic ppu_pkg::vmode_e expected_vmode(ppu_pkg::ppu_cfg_t cfg, logic pal_flag);
    logic            pal_table;
    ppu_pkg::vmode_e m;
    pal_table = pal_flag;
    // low-latency mode ignores both force bits
    if (!cfg.llm && cfg.force60) begin
      pal_table = 1'b0;
    end else if (!cfg.llm && cfg.force50) begin
      pal_table = 1'b1;
    end
    case (cfg.target_res)
      ppu_pkg::TARGET_720P:  m = pal_table ? ppu_pkg::VMODE_720P50 : ppu_pkg::VMODE_720P60;
      ppu_pkg::TARGET_960P:  m = pal_table ? ppu_pkg::VMODE_960P50 : ppu_pkg::VMODE_960P60;
      ppu_pkg::TARGET_1080P: m = pal_table ? ppu_pkg::VMODE_1080P50 : ppu_pkg::VMODE_1080P60;
      ppu_pkg::TARGET_1200P: m = pal_table ? ppu_pkg::VMODE_1200P50 : ppu_pkg::VMODE_1200P60;
      default: begin
        if (pal_table) begin
          m = ppu_pkg::VMODE_576P50;
        end else begin
          m = cfg.use_vga_480p ? ppu_pkg::VMODE_VGA60 : ppu_pkg::VMODE_480P60;
        end
      end
    endcase
    return m;
  endfunction

  // strength code s gives level (s+1)*16-1
  function automatic int unsigned strength_level(ppu_pkg::sl_str_t s);
    int unsigned lvl;
    lvl = 32'(s);
    return (lvl + 1) * 16 - 1;
  endfunction

  function automatic ppu_pkg::color_t darken_component(ppu_pkg::color_t c, int unsigned level);
    return 8'((32'(c) * (255 - level)) / 256);
  endfunction

  function automatic ppu_pkg::color_t limit_component(ppu_pkg::color_t c);
    return 8'((32'(c) * 220 + 128) / 256 + 16);
  endfunction

  function automatic ppu_pkg::vid_word_t predict_beat(ppu_pkg::vid_word_t v, logic draw,
                                                      ppu_pkg::ppu_cfg_t cfg, logic intl);
    ppu_pkg::vid_word_t o;
    logic               en;
    int unsigned        level;
    o = v;
    if (intl) begin
      en    = cfg.sl480_en;
      level = strength_level(cfg.sl480_linked ? cfg.sl240_str : cfg.sl480_str);
    end else begin
      en    = cfg.sl240_en;
      level = strength_level(cfg.sl240_str);
    end
    if (en && draw && v.de) begin
      o.rgb.red   = darken_component(v.rgb.red, level);
      o.rgb.green = darken_component(v.rgb.green, level);
      o.rgb.blue  = darken_component(v.rgb.blue, level);
    end
    // limited range applies after the scanline
    if (cfg.limited_rgb) begin
      o.rgb.red   = limit_component(o.rgb.red);
      o.rgb.green = limit_component(o.rgb.green);
      o.rgb.blue  = limit_component(o.rgb.blue);
    end
    return o;
  endfunction

`endif

/* tb/tb_ppu_tx.sv */
// testbench for the VCLK_Tx post-processing top with random stimulus checked against a model

`timescale 1ns/1ns
`default_nettype none

module tb_ppu_tx;

  localparam int unsigned CLK_PERIOD = 8;
  localparam int unsigned SEGMENTS   = 40;
  localparam int unsigned SEG_CYCLES = 200;
  localparam int unsigned SETTLE     = 8;
  localparam int unsigned LATENCY    = 4;
  localparam int unsigned RST_CYCLES = 2;
  // whole run plus 100 spare cycles
  localparam int unsigned TIMEOUT_NS = (SEGMENTS * SEG_CYCLES + RST_CYCLES + 100) * CLK_PERIOD;

  logic                VCLK_Tx;
  logic                nVRST_Tx;
  ppu_pkg::ppu_cfg_t   cfg;
  logic                pal;
  logic                interlaced;
  ppu_pkg::vid_word_t  vid_in;
  logic                draw_sl;
  ppu_pkg::vid_word_t  vid_out;
  ppu_pkg::ppu_state_t state_out;

  // predicted beats in flight through the DUT
  ppu_pkg::vid_word_t  expect_q[$];
  int unsigned         checks;
  int unsigned         vid_errors;
  int unsigned         state_errors;

  `include "ppu_tx_model.svh"

  ppu_tx_top uut (
    .VCLK_Tx      (VCLK_Tx),
    .nVRST_Tx     (nVRST_Tx),
    .cfg_i        (cfg),
    .pal_i        (pal),
    .interlaced_i (interlaced),
    .vid_i        (vid_in),
    .draw_sl_i    (draw_sl),
    .vid_o        (vid_out),
    .state_o      (state_out)
  );

  initial begin
    VCLK_Tx = 1'b0;
    forever #(CLK_PERIOD / 2) VCLK_Tx = ~VCLK_Tx;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("ERROR: run timed out after %0d ns before all segments finished", TIMEOUT_NS);
    $display("sim failed");
    $finish;
  end

  // ======================================================================
  // stimulus helpers
  // ======================================================================

  function automatic ppu_pkg::ppu_cfg_t random_config();
    ppu_pkg::ppu_cfg_t c;
    logic [2:0]        t;
    c              = '0;
    t              = 3'($urandom_range(4, 0));
    c.target_res   = ppu_pkg::target_res_e'(t);
    c.use_vga_480p = 1'($urandom);
    c.force60      = 1'($urandom);
    c.force50      = 1'($urandom);
    c.llm          = 1'($urandom);
    c.limited_rgb  = 1'($urandom);
    c.sl240_en     = 1'($urandom);
    c.sl240_str    = 4'($urandom);
    c.sl480_en     = 1'($urandom);
    c.sl480_str    = 4'($urandom);
    c.sl480_linked = 1'($urandom);
    return c;
  endfunction

  function automatic ppu_pkg::vid_word_t random_beat();
    ppu_pkg::vid_word_t v;
    v.vsync     = 1'($urandom);
    v.hsync     = 1'($urandom);
    // mostly active video
    v.de        = ($urandom_range(3, 0) != 0);
    v.rgb.red   = 8'($urandom);
    v.rgb.green = 8'($urandom);
    v.rgb.blue  = 8'($urandom);
    return v;
  endfunction

  task automatic check_video(ppu_pkg::vid_word_t exp_vid);
    checks++;
    assert (vid_out == exp_vid) else begin
      vid_errors++;
      $display("MISMATCH at %0t ns: vid_o %h, expected %h", $time, vid_out, exp_vid);
    end
  endtask

  task automatic check_state(ppu_pkg::ppu_state_t exp_state);
    checks++;
    assert (state_out == exp_state) else begin
      state_errors++;
      $display("MISMATCH at %0t ns: state_o %h, expected %h", $time, state_out, exp_state);
    end
  endtask

  // ======================================================================
  // main sequence
  // ======================================================================

  initial begin
    ppu_pkg::ppu_state_t exp_state;
    void'($urandom(32'h8065));
    checks       = 0;
    vid_errors   = 0;
    state_errors = 0;
    nVRST_Tx     = 1'b0;
    cfg          = random_config();
    pal          = 1'b1;
    interlaced   = 1'b1;
    vid_in       = random_beat();
    draw_sl      = 1'b1;

    repeat (RST_CYCLES) @(posedge VCLK_Tx);
    @(negedge VCLK_Tx);
    nVRST_Tx = 1'b1;
    check_video('0);
    check_state('0);

    for (int seg = 0; seg < SEGMENTS; seg++) begin
      for (int cyc = 0; cyc < SEG_CYCLES; cyc++) begin
        @(negedge VCLK_Tx);
        if (expect_q.size() == LATENCY) begin
          if (cyc >= SETTLE) begin
            check_video(expect_q[0]);
          end
          void'(expect_q.pop_front());
        end
        if (cyc == 0) begin
          cfg        = random_config();
          pal        = 1'($urandom);
          interlaced = 1'($urandom);
        end
        if (cyc >= SETTLE) begin
          exp_state.vmode            = expected_vmode(cfg, pal);
          exp_state.input_pal        = pal;
          exp_state.input_interlaced = interlaced;
          check_state(exp_state);
        end
        vid_in  = random_beat();
        draw_sl = 1'($urandom);
        expect_q.push_back(predict_beat(vid_in, draw_sl, cfg, interlaced));
      end
    end

    // beats still in the pipeline
    while (expect_q.size() > 0) begin
      @(negedge VCLK_Tx);
      check_video(expect_q.pop_front());
    end

    $display("checks %0d, video errors %0d, state errors %0d", checks, vid_errors, state_errors);
    if (vid_errors + state_errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* rtl/ppu_tx_top.sv */
// VCLK_Tx post-processing top, config decode then scanlines then range limit

`timescale 1ns/1ns
`default_nettype none

module ppu_tx_top (
  input  wire                 VCLK_Tx,
  input  wire                 nVRST_Tx,
  input  ppu_pkg::ppu_cfg_t   cfg_i,
  input  wire                 pal_i,
  input  wire                 interlaced_i,
  input  ppu_pkg::vid_word_t  vid_i,
  input  wire                 draw_sl_i,
  output ppu_pkg::vid_word_t  vid_o,
  output ppu_pkg::ppu_state_t state_o
);

  ppu_pkg::sl_cfg_t   sl_cfg;
  logic               limited_rgb;
  ppu_pkg::vid_word_t vid_sl;

  // ======================================================================
  // configuration
  // ======================================================================

  tx_cfg_decode cfg_decode_u (
    .VCLK_Tx       (VCLK_Tx),
    .nVRST_Tx      (nVRST_Tx),
    .cfg_i         (cfg_i),
    .pal_i         (pal_i),
    .interlaced_i  (interlaced_i),
    .sl_cfg_o      (sl_cfg),
    .limited_rgb_o (limited_rgb),
    .state_o       (state_o)
  );

  // ======================================================================
  // video path, 1 + 3 cycles
  // ======================================================================

  scanline_emu scanline_emu_u (
    .VCLK_Tx   (VCLK_Tx),
    .nVRST_Tx  (nVRST_Tx),
    .vid_i     (vid_i),
    .draw_sl_i (draw_sl_i),
    .sl_cfg_i  (sl_cfg),
    .vid_o     (vid_sl)
  );

  rgb_range_limiter range_limiter_u (
    .VCLK_Tx       (VCLK_Tx),
    .nVRST_Tx      (nVRST_Tx),
    .limited_rgb_i (limited_rgb),
    .vid_i         (vid_sl),
    .vid_o         (vid_o)
  );

endmodule

`default_nettype wire

/* rtl/rgb_range_limiter.sv */
// limited-range RGB stage, three cycles for both limited and full-range output

`timescale 1ns/1ns
`default_nettype none

module rgb_range_limiter (
  input  wire                VCLK_Tx,
  input  wire                nVRST_Tx,
  input  wire                limited_rgb_i,
  input  ppu_pkg::vid_word_t vid_i,
  output ppu_pkg::vid_word_t vid_o
);

  // top nine bits of c * 220
  function automatic logic [ppu_pkg::COLOR_W:0] scale_top(ppu_pkg::color_t c);
    logic [2*ppu_pkg::COLOR_W-1:0] prod;
    prod = c * ppu_pkg::LIMIT_COEFF;
    return prod[2*ppu_pkg::COLOR_W-1:ppu_pkg::COLOR_W-1];
  endfunction

  // drop the half bit and round up with it
  function automatic ppu_pkg::color_t round_half(logic [ppu_pkg::COLOR_W:0] v);
    return v[ppu_pkg::COLOR_W:1] + ppu_pkg::color_t'(v[0]);
  endfunction

  // black level only touches the upper nibble, the sum never reaches 240
  function automatic ppu_pkg::color_t add_offset(ppu_pkg::color_t c);
    return {c[ppu_pkg::COLOR_W-1:4] + ppu_pkg::LIMIT_OFFSET[ppu_pkg::COLOR_W-1:4], c[3:0]};
  endfunction

  // ======================================================================
  // pipeline registers
  // ======================================================================

  logic [ppu_pkg::COLOR_W:0] red_s1_q;
  logic [ppu_pkg::COLOR_W:0] green_s1_q;
  logic [ppu_pkg::COLOR_W:0] blue_s1_q;
  ppu_pkg::rgb_t             lim_s2_q;

  // syncs, de and the untouched pixel travel together
  ppu_pkg::vid_word_t        beat_s1_q;
  ppu_pkg::vid_word_t        beat_s2_q;

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      red_s1_q   <= '0;
      green_s1_q <= '0;
      blue_s1_q  <= '0;
      lim_s2_q   <= '0;
      beat_s1_q  <= '0;
      beat_s2_q  <= '0;
      vid_o      <= '0;
    end else begin
      // stage 1
      red_s1_q   <= scale_top(vid_i.rgb.red);
      green_s1_q <= scale_top(vid_i.rgb.green);
      blue_s1_q  <= scale_top(vid_i.rgb.blue);
      beat_s1_q  <= vid_i;

      // stage 2
      lim_s2_q.red   <= round_half(red_s1_q);
      lim_s2_q.green <= round_half(green_s1_q);
      lim_s2_q.blue  <= round_half(blue_s1_q);
      beat_s2_q      <= beat_s1_q;

      // stage 3
      vid_o.vsync <= beat_s2_q.vsync;
      vid_o.hsync <= beat_s2_q.hsync;
      vid_o.de    <= beat_s2_q.de;
      if (limited_rgb_i) begin
        vid_o.rgb.red   <= add_offset(lim_s2_q.red);
        vid_o.rgb.green <= add_offset(lim_s2_q.green);
        vid_o.rgb.blue  <= add_offset(lim_s2_q.blue);
      end else begin
        vid_o.rgb <= beat_s2_q.rgb;
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/scanline_emu.sv */
// scanline emulation, darkens active pixels on lines flagged for a scanline

`timescale 1ns/1ns
`default_nettype none

module scanline_emu (
  input  wire                 VCLK_Tx,
  input  wire                 nVRST_Tx,
  input  ppu_pkg::vid_word_t  vid_i,
  input  wire                 draw_sl_i,
  input  ppu_pkg::sl_cfg_t    sl_cfg_i,
  output ppu_pkg::vid_word_t  vid_o
);

  // c * gain / 256, truncated
  function automatic ppu_pkg::color_t darken(ppu_pkg::color_t c, ppu_pkg::color_t gain);
    logic [2*ppu_pkg::COLOR_W-1:0] prod;
    prod = c * gain;
    return prod[2*ppu_pkg::COLOR_W-1:ppu_pkg::COLOR_W];
  endfunction

  ppu_pkg::color_t sl_gain;
  logic            sl_active;

  // 255 - level
  assign sl_gain   = ~sl_cfg_i.sl_level;
  assign sl_active = sl_cfg_i.sl_en & draw_sl_i & vid_i.de;

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      vid_o <= '0;
    end else begin
      vid_o.vsync <= vid_i.vsync;
      vid_o.hsync <= vid_i.hsync;
      vid_o.de    <= vid_i.de;
      if (sl_active) begin
        vid_o.rgb.red   <= darken(vid_i.rgb.red, sl_gain);
        vid_o.rgb.green <= darken(vid_i.rgb.green, sl_gain);
        vid_o.rgb.blue  <= darken(vid_i.rgb.blue, sl_gain);
      end else begin
        vid_o.rgb <= vid_i.rgb;
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/tx_cfg_decode.sv */
// config and video-info resync into VCLK_Tx with video mode and scanline decode

`timescale 1ns/1ns
`default_nettype none

module tx_cfg_decode (
  input  wire                VCLK_Tx,
  input  wire                nVRST_Tx,
  input  ppu_pkg::ppu_cfg_t  cfg_i,
  input  wire                pal_i,
  input  wire                interlaced_i,
  output ppu_pkg::sl_cfg_t   sl_cfg_o,
  output logic               limited_rgb_o,
  output ppu_pkg::ppu_state_t state_o
);

  // ======================================================================
  // two-flop resync
  // ======================================================================

  ppu_pkg::ppu_cfg_t cfg_meta_q;
  ppu_pkg::ppu_cfg_t cfg_sync_q;
  logic              pal_meta_q;
  logic              pal_sync_q;
  logic              intl_meta_q;
  logic              intl_sync_q;

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      cfg_meta_q  <= '0;
      cfg_sync_q  <= '0;
      pal_meta_q  <= 1'b0;
      pal_sync_q  <= 1'b0;
      intl_meta_q <= 1'b0;
      intl_sync_q <= 1'b0;
    end else begin
      cfg_meta_q  <= cfg_i;
      cfg_sync_q  <= cfg_meta_q;
      pal_meta_q  <= pal_i;
      pal_sync_q  <= pal_meta_q;
      intl_meta_q <= interlaced_i;
      intl_sync_q <= intl_meta_q;
    end
  end

  // ======================================================================
  // video mode tables
  // ======================================================================

  ppu_pkg::vmode_e vmode_ntsc;
  ppu_pkg::vmode_e vmode_pal;
  logic            use_pal;

  always_comb begin
    case (cfg_sync_q.target_res)
      ppu_pkg::TARGET_1200P: begin
        vmode_ntsc = ppu_pkg::VMODE_1200P60;
        vmode_pal  = ppu_pkg::VMODE_1200P50;
      end
      ppu_pkg::TARGET_1080P: begin
        vmode_ntsc = ppu_pkg::VMODE_1080P60;
        vmode_pal  = ppu_pkg::VMODE_1080P50;
      end
      ppu_pkg::TARGET_960P: begin
        vmode_ntsc = ppu_pkg::VMODE_960P60;
        vmode_pal  = ppu_pkg::VMODE_960P50;
      end
      ppu_pkg::TARGET_720P: begin
        vmode_ntsc = ppu_pkg::VMODE_720P60;
        vmode_pal  = ppu_pkg::VMODE_720P50;
      end
      // 480p and any unused code
      default: begin
        vmode_ntsc = cfg_sync_q.use_vga_480p ? ppu_pkg::VMODE_VGA60 : ppu_pkg::VMODE_480P60;
        vmode_pal  = ppu_pkg::VMODE_576P50;
      end
    endcase
  end

  // forcing 50/60 Hz is ignored in low-latency mode
  always_comb begin
    if (cfg_sync_q.force60 && !cfg_sync_q.llm) begin
      use_pal = 1'b0;
    end else if (cfg_sync_q.force50 && !cfg_sync_q.llm) begin
      use_pal = 1'b1;
    end else begin
      use_pal = pal_sync_q;
    end
  end

  // ======================================================================
  // scanline settings
  // ======================================================================

  logic             sl_en_sel;
  ppu_pkg::sl_str_t sl_str_sel;

  always_comb begin
    if (!intl_sync_q) begin
      sl_en_sel  = cfg_sync_q.sl240_en;
      sl_str_sel = cfg_sync_q.sl240_str;
    end else begin
      sl_en_sel  = cfg_sync_q.sl480_en;
      sl_str_sel = cfg_sync_q.sl480_linked ? cfg_sync_q.sl240_str : cfg_sync_q.sl480_str;
    end
  end

  // ======================================================================
  // decode register
  // ======================================================================

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      state_o       <= '0;
      sl_cfg_o      <= '0;
      limited_rgb_o <= 1'b0;
    end else begin
      state_o.vmode            <= use_pal ? vmode_pal : vmode_ntsc;
      state_o.input_pal        <= pal_sync_q;
      state_o.input_interlaced <= intl_sync_q;
      sl_cfg_o.sl_en           <= sl_en_sel;
      // (s+1)*16-1 is just s with a low nibble of ones
      sl_cfg_o.sl_level        <= {sl_str_sel, 4'hF};
      limited_rgb_o            <= cfg_sync_q.limited_rgb;
    end
  end

endmodule

`default_nettype wire

/* rtl/ppu_pkg.sv */
// shared types and constants for the VCLK_Tx video post-processing path

`default_nettype none

package ppu_pkg;

  // ======================================================================
  // video beat
  // ======================================================================

  localparam int unsigned COLOR_W = 8;

  typedef logic [COLOR_W-1:0] color_t;

  typedef struct packed {
    color_t red;
    color_t green;
    color_t blue;
  } rgb_t;

  // one beat per VCLK_Tx cycle, 27 bits
  typedef struct packed {
    logic vsync;
    logic hsync;
    logic de;
    rgb_t rgb;
  } vid_word_t;

  // ======================================================================
  // configuration
  // ======================================================================

  // user strength code and its expanded darkening level
  typedef logic [3:0]         sl_str_t;
  typedef logic [COLOR_W-1:0] sl_level_t;

  typedef enum logic [2:0] {
    TARGET_480P  = 3'd0,
    TARGET_720P  = 3'd1,
    TARGET_960P  = 3'd2,
    TARGET_1080P = 3'd3,
    TARGET_1200P = 3'd4
  } target_res_e;

  // 480p60 must stay at zero, it is the reset mode
  typedef enum logic [3:0] {
    VMODE_480P60  = 4'd0,
    VMODE_VGA60   = 4'd1,
    VMODE_720P60  = 4'd2,
    VMODE_960P60  = 4'd3,
    VMODE_1080P60 = 4'd4,
    VMODE_1200P60 = 4'd5,
    VMODE_576P50  = 4'd6,
    VMODE_720P50  = 4'd7,
    VMODE_960P50  = 4'd8,
    VMODE_1080P50 = 4'd9,
    VMODE_1200P50 = 4'd10
  } vmode_e;

  // 22-bit config word, top bits are spare
  typedef struct packed {
    logic [2:0]  reserved;
    target_res_e target_res;
    logic        use_vga_480p;
    logic        force60;
    logic        force50;
    logic        llm;
    logic        limited_rgb;
    logic        sl240_en;
    sl_str_t     sl240_str;
    logic        sl480_en;
    sl_str_t     sl480_str;
    logic        sl480_linked;
  } ppu_cfg_t;

  typedef struct packed {
    logic      sl_en;
    sl_level_t sl_level;
  } sl_cfg_t;

  typedef struct packed {
    vmode_e vmode;
    logic   input_pal;
    logic   input_interlaced;
  } ppu_state_t;

  // limited range: c * 220 / 256 + 16
  localparam logic [COLOR_W-1:0] LIMIT_COEFF  = 8'd220;
  localparam logic [COLOR_W-1:0] LIMIT_OFFSET = 8'd16;

endpackage

`default_nettype wire
